// ==== all.f ====
+incdir+include
verilog/mips_pkg.sv
verilog/ctrl_if.sv
verilog/mips_decoder.sv
verilog/register_file.sv
verilog/mips_execute.sv
verilog/mips_writeback.sv
verilog/mips_core.sv
tb/tb_mips_core.sv

// ==== include/mips_test_program.svh ====
/*
 * Test programs and instruction-level model for the MIPS core
 * one program image per test, and a model that retires one
 * instruction per call and predicts the core's outputs
 */
`ifndef MIPS_TEST_PROGRAM_SVH
`define MIPS_TEST_PROGRAM_SVH

function automatic word_t enc_r(input logic [5:0] fn, input int rs, input int rt, input int rd);
  return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic word_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                input logic [15:0] imm);
  return {op, 5'(rs), 5'(rt), imm};
endfunction

task automatic emit(input word_t w);
  imem[n_instr] = w;
  n_instr++;
endtask

task automatic build_program(input int test_id);
  word_t  rnd;
  funct_t fns [5];
  fns = '{fn_add, fn_sub, fn_and, fn_or, fn_slt};
  rnd = $urandom;
  n_instr = 0;
  // unused words hold unknown opcodes tagged with their index
  for (int i = 0; i < 256; i++) begin
    imem[i] = {6'h3f, 18'h0, i[7:0]};
  end
  case (test_id)
    0: begin
      emit(enc_i(op_addi, 0, 1, {1'b0, rnd[14:0]}));
      emit(enc_i(op_addi, 0, 2, {1'b1, rnd[30:16]}));
      emit(enc_i(op_addi, 2, 3, {1'b1, rnd[14:0]}));
      for (int k = 0; k < 5; k++) begin
        emit(enc_r(fns[k], 1, 2, 10 + k));
        emit(enc_i(op_sw, 0, 10 + k, 16'(4 * k)));
      end
      // negative against positive, then two negatives both ways
      emit(enc_r(fn_slt, 2, 1, 16));
      emit(enc_r(fn_slt, 3, 2, 17));
      emit(enc_r(fn_slt, 2, 3, 18));
      for (int k = 16; k < 19; k++) begin
        emit(enc_i(op_sw, 0, k, 16'(4 * k)));
      end
    end
    1: begin
      emit(enc_i(op_addi, 0, 1, rnd[15:0]));
      emit(enc_i(op_addi, 0, 2, 16'd64));
      emit(enc_i(op_sw, 2, 1, 16'd8));
      emit(enc_i(op_lw, 2, 3, 16'd8));
      emit(enc_i(op_sw, 2, 3, 16'd12));
      // writes to r0 are lost
      emit(enc_i(op_addi, 0, 0, 16'h1234));
      emit(enc_i(op_lw, 2, 0, 16'd8));
      emit(enc_i(op_sw, 2, 0, 16'd16));
      emit(enc_i(op_lw, 0, 4, 16'h0200));
      emit(enc_i(op_sw, 2, 4, 16'hfffc));
    end
    2: begin
      emit(enc_i(op_addi, 0, 1, 16'd5));
      emit(enc_i(op_addi, 0, 3, 16'd7));
      emit(enc_i(op_addi, 0, 2, 16'd5));
      emit(enc_i(op_beq, 1, 3, 16'd2));
      emit(enc_i(op_beq, 1, 2, 16'd2));
      emit(enc_i(op_sw, 0, 1, 16'd0));
      emit(enc_i(op_sw, 0, 1, 16'd4));
      // count r4 up to r1, looping back with a negative offset
      emit(enc_i(op_addi, 4, 4, 16'd1));
      emit(enc_i(op_beq, 4, 1, 16'd1));
      emit(enc_i(op_beq, 0, 0, 16'hfffd));
      emit(enc_i(op_sw, 0, 4, 16'd32));
    end
    default: begin
      emit({op_j, 26'd3});
      emit(enc_i(op_sw, 0, 0, 16'd0));
      emit(enc_i(op_sw, 0, 0, 16'd4));
      emit(enc_i(op_addi, 0, 5, rnd[15:0]));
      emit({6'h3f, rnd[25:0]});
      emit(enc_r(6'h3f, 5, 5, 5));
      emit(enc_i(op_sw, 0, 5, 16'd40));
    end
  endcase
  // program ends in a jump to itself
  halt_pc = word_t'(4 * n_instr);
  emit({op_j, 26'(n_instr)});
endtask

task automatic model_step();
  word_t w;
  word_t a;
  word_t b;
  word_t imm;
  word_t addr;
  word_t nxt;
  w      = imem[m_pc[9:2]];
  a      = m_regs[w[25:21]];
  b      = m_regs[w[20:16]];
  imm    = {{16{w[15]}}, w[15:0]};
  addr   = a + imm;
  nxt    = m_pc + 32'd4;
  exp_pc = m_pc;
  exp_we = 1'b0;
  case (w[31:26])
    6'd0: begin
      case (w[5:0])
        6'd32: m_regs[w[15:11]] = a + b;
        6'd34: m_regs[w[15:11]] = a - b;
        6'd36: m_regs[w[15:11]] = a & b;
        6'd37: m_regs[w[15:11]] = a | b;
        6'd42: m_regs[w[15:11]] = word_t'($signed(a) < $signed(b));
        default: ;
      endcase
    end
    6'd8:  m_regs[w[20:16]] = addr;
    6'd35: m_regs[w[20:16]] = m_dmem[addr[9:2]];
    6'd43: begin
      exp_we    = 1'b1;
      exp_addr  = addr;
      exp_wdata = b;
      m_dmem[addr[9:2]] = b;
    end
    6'd4: begin
      if (a == b) begin
        nxt = nxt + {imm[29:0], 2'b00};
      end
    end
    6'd2: nxt = {nxt[31:28], w[25:0], 2'b00};
    default: ;
  endcase
  m_regs[0] = '0;
  m_pc      = nxt;
endtask

`endif

// ==== tb/tb_mips_core.sv ====
/*
 * Testbench for the single-cycle MIPS core
 * runs four short programs against an instruction-level model
 * and checks pc and data-memory writes on every clock
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core import mips_pkg::*; ();

  localparam int clk_period      = 40;
  localparam int reset_cycles    = 8;
  localparam int test_count      = 4;
  // upper bound on the cycles of one program with its loops
  localparam int max_test_cycles = 64;
  localparam int watchdog_ns     =
    test_count * (reset_cycles + max_test_cycles) * clk_period + 1000;

  logic  clk;
  logic  rst_n;
  word_t imem_addr;
  word_t imem_rdata;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic  dmem_we;
  word_t dmem_rdata;
  word_t pc;

  word_t imem [256];
  word_t dmem [256];
  int    n_instr;
  word_t halt_pc;

  // reference model state and its prediction for the current cycle
  word_t m_regs [32];
  word_t m_pc;
  word_t m_dmem [256];
  word_t exp_pc;
  logic  exp_we;
  word_t exp_addr;
  word_t exp_wdata;

  int    test_errors;
  int    total_errors;
  int    tests_failed;
  string test_names [test_count];

  `include "mips_test_program.svh"

  mips_core #(
    .reset_pc (32'h0000_0000)
  ) u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .pc         (pc)
  );

  always #(clk_period / 2) clk = ~clk;

  // memories answer in the same cycle
  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  // compare with the model at every rising edge out of reset
  always @(posedge clk) begin
    if (rst_n) begin
      assert (pc === exp_pc && imem_addr === exp_pc) else begin
        $display("mismatch at %0t ns: pc %h, fetch address %h, expected %h",
                 $time, pc, imem_addr, exp_pc);
        test_errors++;
      end
      assert (dmem_we === exp_we) else begin
        $display("mismatch at %0t ns: dmem_we %b, expected %b", $time, dmem_we, exp_we);
        test_errors++;
      end
      if (exp_we) begin
        assert (dmem_addr === exp_addr && dmem_wdata === exp_wdata) else begin
          $display("mismatch at %0t ns: store %h to %h, expected %h to %h",
                   $time, dmem_wdata, dmem_addr, exp_wdata, exp_addr);
          test_errors++;
        end
      end
    end
  end

  task automatic apply_reset();
    word_t first_word;
    // a store at the reset address must stay silent in reset
    first_word = imem[0];
    imem[0]    = enc_i(op_sw, 0, 0, 16'd0);
    rst_n      = 1'b0;
    repeat (reset_cycles) begin
      @(posedge clk);
      @(negedge clk);
      assert (pc === 32'h0 && dmem_we === 1'b0) else begin
        $display("mismatch at %0t ns: pc %h, dmem_we %b in reset", $time, pc, dmem_we);
        test_errors++;
      end
    end
    imem[0] = first_word;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc  = 32'h0;
    rst_n = 1'b1;
    model_step();
  endtask

  initial begin
    int unsigned seed;
    seed = 32'hd5ac;
    void'($urandom(seed));
    clk          = 1'b0;
    rst_n        = 1'b0;
    total_errors = 0;
    tests_failed = 0;
    test_names   = '{"arithmetic", "load and store", "branch", "jump and unknown"};
    for (int i = 0; i < 256; i++) begin
      dmem[i]   = 32'hc0de_0000 ^ (i * 32'h0001_0003);
      m_dmem[i] = dmem[i];
    end
    for (int t = 0; t < test_count; t++) begin
      test_errors = 0;
      build_program(t);
      apply_reset();
      while (exp_pc != halt_pc) begin
        @(negedge clk);
        model_step();
      end
      // the edge in between checks the halt cycle
      @(negedge clk);
      $display("test %0d (%s): %s, %0d errors", t, test_names[t],
               (test_errors == 0) ? "pass" : "fail", test_errors);
      total_errors += test_errors;
      if (test_errors != 0) begin
        tests_failed++;
      end
    end
    $display("%0d tests run, %0d failed, %0d errors", test_count, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout after %0d ns, a program never reached its final jump", watchdog_ns);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/ctrl_if.sv ====
/*
 * Decoded control bundle
 * carries control from the decoder to execute and writeback
 */
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if import mips_pkg::*; ();

  logic         reg_dst;
  logic         alu_src;
  logic         mem_to_reg;
  logic         reg_write;
  logic         mem_write;
  logic         branch;
  logic         jump;
  alu_op_t      alu_op;
  // sign-extended immediate
  word_t        imm_ext;
  logic  [25:0] jump_target;

  modport decoder (
    output reg_dst, alu_src, mem_to_reg, reg_write, mem_write,
    output branch, jump, alu_op, imm_ext, jump_target
  );

  modport exec (
    input alu_src, branch, jump, alu_op, imm_ext, jump_target, mem_write
  );

  modport wb (
    input reg_dst, mem_to_reg, reg_write
  );

endinterface

`default_nettype wire

// ==== verilog/mips_core.sv ====
/*
 * Single-cycle MIPS core
 * one instruction retired per clock, instruction and data
 * memories outside, answering combinationally
 */
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; #(
  parameter word_t reset_pc = 32'h0000_0000
) (
  input  logic  clk,
  input  logic  rst_n,
  // instruction memory
  output word_t imem_addr,
  input  word_t imem_rdata,
  // data memory
  output word_t dmem_addr,
  output word_t dmem_wdata,
  output logic  dmem_we,
  input  word_t dmem_rdata,
  output word_t pc
);

  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  word_t     rd1;
  word_t     rd2;
  word_t     alu_result;
  word_t     store_data;
  reg_addr_t wa;
  word_t     wd;
  logic      we;

  ctrl_if ctrl_bus ();

  mips_decoder u_decoder (
    .instr (imem_rdata),
    .rs    (rs),
    .rt    (rt),
    .rd    (rd),
    .ctrl  (ctrl_bus)
  );

  register_file u_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .ra1   (rs),
    .ra2   (rt),
    .rd1   (rd1),
    .rd2   (rd2),
    .wa    (wa),
    .wd    (wd),
    .we    (we)
  );

  mips_execute #(
    .reset_pc (reset_pc)
  ) u_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl_bus),
    .rd1        (rd1),
    .rd2        (rd2),
    .alu_result (alu_result),
    .store_data (store_data),
    .dmem_we    (dmem_we),
    .pc         (pc)
  );

  mips_writeback u_writeback (
    .rst_n      (rst_n),
    .ctrl       (ctrl_bus),
    .rt         (rt),
    .rd         (rd),
    .alu_result (alu_result),
    .load_data  (dmem_rdata),
    .wa         (wa),
    .wd         (wd),
    .we         (we)
  );

  // fetch from the current PC
  assign imem_addr = pc;

  // ALU computes the load/store address
  assign dmem_addr  = alu_result;
  assign dmem_wdata = store_data;

endmodule

`default_nettype wire

// ==== verilog/mips_decoder.sv ====
/*
 * Instruction decoder
 * main decode on the opcode, ALU decode on funct,
 * immediate sign extension and register number extraction
 */
`timescale 1ns/1ps
`default_nettype none

module mips_decoder import mips_pkg::*; (
  input  word_t          instr,
  output reg_addr_t      rs,
  output reg_addr_t      rt,
  output reg_addr_t      rd,
  ctrl_if.decoder        ctrl
);

  instr_u  iw;
  alu_op_t r_alu_op;
  logic    funct_ok;

  assign iw = instr;

  // register numbers sit at the same place in both forms
  assign rs = iw.r.rs;
  assign rt = iw.r.rt;
  assign rd = iw.r.rd;

  assign ctrl.imm_ext     = {{16{iw.i.imm[15]}}, iw.i.imm};
  assign ctrl.jump_target = instr[25:0];

  // ALU decode of R-type funct
  always_comb begin
    r_alu_op = alu_add;
    funct_ok = 1'b1;
    case (iw.r.funct)
      fn_add: r_alu_op = alu_add;
      fn_sub: r_alu_op = alu_sub;
      fn_and: r_alu_op = alu_and;
      fn_or:  r_alu_op = alu_or;
      fn_slt: r_alu_op = alu_slt;
      default: begin
        r_alu_op = alu_add;
        funct_ok = 1'b0;
      end
    endcase
  end

  // main decode
  always_comb begin
    // no-op defaults, also used for unknown opcodes
    ctrl.reg_dst    = 1'b0;
    ctrl.alu_src    = 1'b0;
    ctrl.mem_to_reg = 1'b0;
    ctrl.reg_write  = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.branch     = 1'b0;
    ctrl.jump       = 1'b0;
    ctrl.alu_op     = alu_add;
    case (iw.i.op)
      op_rtype: begin
        ctrl.reg_dst   = 1'b1;
        // unknown funct writes nothing
        ctrl.reg_write = funct_ok;
        ctrl.alu_op    = r_alu_op;
      end
      op_lw: begin
        ctrl.alu_src    = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_write  = 1'b1;
      end
      op_sw: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      op_beq: begin
        // compare by subtraction, zero flag decides
        ctrl.branch = 1'b1;
        ctrl.alu_op = alu_sub;
      end
      op_addi: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      op_j: begin
        ctrl.jump = 1'b1;
      end
      default: begin
        ctrl.alu_op = alu_add;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/mips_execute.sv ====
/*
 * Execute stage
 * operand select, ALU with zero flag, program counter
 * and next-PC choice among sequential, branch and jump
 */
`timescale 1ns/1ps
`default_nettype none

module mips_execute import mips_pkg::*; #(
  parameter word_t reset_pc = 32'h0000_0000
) (
  input  logic     clk,
  input  logic     rst_n,
  ctrl_if.exec     ctrl,
  input  word_t    rd1,
  input  word_t    rd2,
  output word_t    alu_result,
  output word_t    store_data,
  output logic     dmem_we,
  output word_t    pc
);

  word_t src_b;
  logic  zero;
  word_t pc_q;
  word_t pc_plus4;
  word_t branch_target;
  word_t jump_addr;
  word_t next_pc;

  assign src_b = ctrl.alu_src ? ctrl.imm_ext : rd2;

  always_comb begin
    case (ctrl.alu_op)
      alu_add: alu_result = rd1 + src_b;
      alu_sub: alu_result = rd1 - src_b;
      alu_and: alu_result = rd1 & src_b;
      alu_or:  alu_result = rd1 | src_b;
      // signed compare
      alu_slt: alu_result = {31'b0, ($signed(rd1) < $signed(src_b))};
      default: alu_result = rd1 + src_b;
    endcase
  end

  assign zero = (alu_result == '0);

  // store data is always the rt value
  assign store_data = rd2;
  assign dmem_we    = ctrl.mem_write & rst_n;

  // next PC candidates
  assign pc_plus4      = pc_q + 32'd4;
  assign branch_target = pc_plus4 + {ctrl.imm_ext[29:0], 2'b00};
  assign jump_addr     = {pc_plus4[31:28], ctrl.jump_target, 2'b00};

  always_comb begin
    if (ctrl.jump) begin
      next_pc = jump_addr;
    end else if (ctrl.branch && zero) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= reset_pc;
    end else begin
      pc_q <= next_pc;
    end
  end

  assign pc = pc_q;

endmodule

`default_nettype wire

// ==== verilog/mips_pkg.sv ====
/*
 * MIPS core shared definitions
 * opcodes, funct codes, ALU operations and the two views
 * of the 32-bit instruction word
 */
`default_nettype none

package mips_pkg;

  // data, addresses and PC
  typedef logic [31:0] word_t;

  // register number
  typedef logic [4:0] reg_addr_t;

  // major opcodes of the supported subset
  typedef enum logic [5:0] {
    op_rtype = 6'd0,
    op_j     = 6'd2,
    op_beq   = 6'd4,
    op_addi  = 6'd8,
    op_lw    = 6'd35,
    op_sw    = 6'd43
  } opcode_t;

  // funct field of R-type instructions
  typedef enum logic [5:0] {
    fn_add = 6'd32,
    fn_sub = 6'd34,
    fn_and = 6'd36,
    fn_or  = 6'd37,
    fn_slt = 6'd42
  } funct_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_t;

  // R-form layout
  typedef struct packed {
    opcode_t   op;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [4:0] shamt;
    funct_t    funct;
  } r_fields_t;

  // I-form layout
  typedef struct packed {
    opcode_t     op;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [15:0] imm;
  } i_fields_t;

  // one instruction word, two decodings
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_u;

endpackage

`default_nettype wire

// ==== verilog/mips_writeback.sv ====
/*
 * Writeback select
 * picks the destination register and the result source
 * and drives the register file write port
 */
`timescale 1ns/1ps
`default_nettype none

module mips_writeback import mips_pkg::*; (
  input  logic      rst_n,
  ctrl_if.wb        ctrl,
  input  reg_addr_t rt,
  input  reg_addr_t rd,
  input  word_t     alu_result,
  input  word_t     load_data,
  output reg_addr_t wa,
  output word_t     wd,
  output logic      we
);

  // rd for R-type, rt for loads and addi
  assign wa = ctrl.reg_dst ? rd : rt;

  // load data or ALU result
  assign wd = ctrl.mem_to_reg ? load_data : alu_result;

  // no register writes while in reset
  assign we = ctrl.reg_write & rst_n;

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
/*
 * Register file
 * 32 x 32 bits, two combinational read ports and one
 * write port on the rising edge, register 0 reads as zero
 */
`timescale 1ns/1ps
`default_nettype none

module register_file import mips_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  output word_t     rd1,
  output word_t     rd2,
  input  reg_addr_t wa,
  input  word_t     wd,
  input  logic      we
);

  word_t regs [32];

  // combinational reads, r0 hardwired
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

endmodule

`default_nettype wire
